/* hdl/rt_settings.svh */
`ifndef RT_SETTINGS_SVH
`define RT_SETTINGS_SVH

// ***************************************************************************
// Frame geometry

`define RT_WIDTH 8       // Pixels per row
`define RT_HEIGHT 4      // Rows per frame

// ***************************************************************************
// Scene and pipeline

`define RT_NUM_BOXES 4     // Entries in the box table
`define RT_NUM_LINKS 3     // Valid/stall links watched by the monitor

// Cycles with items waiting and nothing moving before a hang is flagged
`define RT_HANG_LIMIT 64

`endif

/* hdl/rt_link_pkg.sv */
`include "rt_settings.svh"

package rt_link_pkg;

	// ***********************************************************************
	// Link status

	typedef struct packed {
		logic valid;
		logic stall;     // Receiver not ready
	} link_t;

	typedef link_t [`RT_NUM_LINKS-1:0] link_vec_t;

	typedef logic [$clog2(`RT_HANG_LIMIT+1)-1:0] hang_cnt_t;    // Saturates at the limit

	// ***********************************************************************
	// Frame control

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RUN,      // Rays being issued
		ST_DRAIN,    // Waiting for the pipeline to empty
		ST_DONE,
		ST_HANG      // Sticky until reset
	} ctrl_state_t;

endpackage

/* hdl/rt_scene_pkg.sv */
`include "rt_settings.svh"

package rt_scene_pkg;

	typedef logic [7:0] coord_t;
	typedef logic [7:0] depth_t;     // Smaller is nearer
	typedef logic [7:0] color_t;
	typedef logic [$clog2(`RT_NUM_BOXES)-1:0] box_id_t;

	localparam color_t BG_COLOR = 8'h00;

	typedef struct packed {
		coord_t x;
		coord_t y;
		logic last;      // Final pixel of the frame
	} ray_t;

	typedef struct packed {
		coord_t x_min;
		coord_t x_max;
		coord_t y_min;
		coord_t y_max;
		depth_t z;
		color_t color;
	} box_t;

	typedef struct packed {
		ray_t ray;
		logic hit;
		depth_t depth;
		color_t color;
	} hit_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		color_t color;
		logic last;
	} pixel_t;

	// Bounds are inclusive; boxes 1 and 2 tie on z where they overlap
	localparam box_t BOX_TABLE [`RT_NUM_BOXES] = '{
		'{x_min: 8'd0, x_max: 8'd3, y_min: 8'd0, y_max: 8'd1, z: 8'd40, color: 8'h11},
		'{x_min: 8'd2, x_max: 8'd5, y_min: 8'd1, y_max: 8'd3, z: 8'd20, color: 8'h22},
		'{x_min: 8'd5, x_max: 8'd6, y_min: 8'd0, y_max: 8'd2, z: 8'd20, color: 8'h33},
		'{x_min: 8'd7, x_max: 8'd7, y_min: 8'd3, y_max: 8'd3, z: 8'd10, color: 8'h44}
	};

endpackage

/* hdl/ray_gen.sv */
`timescale 1ns/10ps
`include "rt_settings.svh"

module ray_gen import rt_scene_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	input  logic start,
	output ray_t ray,
	output logic ray_valid,
	input  logic ray_stall,
	output logic gen_done
);

	coord_t x_cnt;
	coord_t y_cnt;
	logic last_pix;

	assign last_pix = (x_cnt == coord_t'(`RT_WIDTH - 1)) && (y_cnt == coord_t'(`RT_HEIGHT - 1));
	assign ray = '{x: x_cnt, y: y_cnt, last: last_pix};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			x_cnt <= '0;
			y_cnt <= '0;
			ray_valid <= 1'b0;
			gen_done <= 1'b0;
		end else if (start && !run && !ray_valid) begin    // New frame
			x_cnt <= '0;
			y_cnt <= '0;
			gen_done <= 1'b0;
		end else if (ray_valid) begin
			if (!ray_stall) begin
				ray_valid <= run && !last_pix;
				if (last_pix) begin
					gen_done <= 1'b1;
				end else if (x_cnt == coord_t'(`RT_WIDTH - 1)) begin
					x_cnt <= '0;
					y_cnt <= y_cnt + 1'b1;
				end else begin
					x_cnt <= x_cnt + 1'b1;
				end
			end
		end else if (run && !gen_done) begin
			ray_valid <= 1'b1;    // First ray of the frame
		end
	end

	// A stalled ray stays on the link unchanged
	a_ray_hold: assert property (@(posedge clk) disable iff (!rst_n)
		ray_valid && ray_stall |=> ray_valid && $stable(ray));

endmodule

/* hdl/box_trav.sv */
`timescale 1ns/10ps
`include "rt_settings.svh"

module box_trav import rt_scene_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  ray_t ray,
	input  logic ray_valid,
	output logic ray_stall,
	output hit_t hit,
	output logic hit_valid,
	input  logic hit_stall,
	output logic busy
);

	typedef enum logic [1:0] {
		TR_IDLE,
		TR_TEST,     // One box per cycle
		TR_HOLD      // Hit on the output link
	} trav_state_t;

	localparam box_id_t LAST_BOX = box_id_t'(`RT_NUM_BOXES - 1);

	trav_state_t state;
	ray_t ray_q;
	box_id_t box_idx;
	logic best_hit;
	depth_t best_z;
	color_t best_color;
	box_t cur_box;
	logic in_box;
	logic nearer;

	// ***********************************************************************
	// Box test

	assign cur_box = BOX_TABLE[box_idx];
	assign in_box = (ray_q.x >= cur_box.x_min) && (ray_q.x <= cur_box.x_max) &&
		(ray_q.y >= cur_box.y_min) && (ray_q.y <= cur_box.y_max);
	assign nearer = in_box && (!best_hit || (cur_box.z < best_z));    // Ties keep lower index

	assign ray_stall = (state != TR_IDLE);
	assign hit_valid = (state == TR_HOLD);
	assign hit = '{ray: ray_q, hit: best_hit, depth: best_z, color: best_color};

	// ***********************************************************************
	// Control

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= TR_IDLE;
			busy <= 1'b0;
		end else begin
			case (state)
				TR_IDLE: begin
					if (ray_valid) begin
						state <= TR_TEST;
						busy <= 1'b1;
					end
				end
				TR_TEST: begin
					if (box_idx == LAST_BOX) state <= TR_HOLD;
				end
				TR_HOLD: begin
					if (!hit_stall) begin    // Hit leaves this cycle
						state <= TR_IDLE;
						busy <= 1'b0;
					end
				end
				default: state <= TR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == TR_IDLE) begin
			ray_q <= ray;
			box_idx <= '0;
			best_hit <= 1'b0;
		end else if (state == TR_TEST) begin
			box_idx <= box_idx + 1'b1;
			if (nearer) begin
				best_hit <= 1'b1;
				best_z <= cur_box.z;
				best_color <= cur_box.color;
			end
		end
	end

	// One cycle per box between accepting a ray and offering its hit
	a_test_time: assert property (@(posedge clk) disable iff (!rst_n)
		ray_valid && !ray_stall |=> !hit_valid [*`RT_NUM_BOXES] ##1 hit_valid);

endmodule

/* hdl/pixel_shader.sv */
`timescale 1ns/10ps

module pixel_shader import rt_scene_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  hit_t hit,
	input  logic hit_valid,
	output logic hit_stall,
	output pixel_t pix,
	output logic pix_valid,
	input  logic pix_stall
);

	color_t shade;

	// Output register frees up in the same cycle its pixel leaves
	assign hit_stall = pix_valid && pix_stall;
	assign shade = hit.hit ? hit.color : BG_COLOR;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pix_valid <= 1'b0;
		end else if (!hit_stall) begin
			pix_valid <= hit_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (hit_valid && !hit_stall) begin
			pix <= '{
				x: hit.ray.x,
				y: hit.ray.y,
				color: shade,
				last: hit.ray.last
			};
		end
	end

endmodule

/* hdl/link_monitor.sv */
`timescale 1ns/10ps
`include "rt_settings.svh"

module link_monitor import rt_link_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  link_vec_t links,
	output logic any_valid,
	output logic any_move,
	output logic stuck
);

	localparam hang_cnt_t HANG_LIMIT = hang_cnt_t'(`RT_HANG_LIMIT);

	hang_cnt_t stall_cnt;

	always_comb begin
		any_valid = 1'b0;
		any_move = 1'b0;
		for (int i = 0; i < `RT_NUM_LINKS; i++) begin
			any_valid = any_valid | links[i].valid;
			any_move = any_move | (links[i].valid & ~links[i].stall);
		end
	end

	// Cycles with work pending and no transfer anywhere
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stall_cnt <= '0;
		end else if (!any_valid || any_move) begin
			stall_cnt <= '0;
		end else if (!stuck) begin
			stall_cnt <= stall_cnt + 1'b1;
		end
	end

	assign stuck = (stall_cnt == HANG_LIMIT);

endmodule

/* hdl/rt_ctrl.sv */
`timescale 1ns/10ps

module rt_ctrl import rt_link_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic gen_done,
	input  logic busy,
	input  logic any_valid,
	input  logic stuck,
	output logic run,
	output logic frame_done,
	output logic hang
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (start) state_nxt = ST_RUN;
			end
			ST_RUN: begin
				if (gen_done) state_nxt = ST_DRAIN;    // Last ray has left ray_gen
			end
			ST_DRAIN: begin
				if (!any_valid && !busy) state_nxt = ST_DONE;
			end
			ST_DONE: begin
				state_nxt = ST_IDLE;
			end
			ST_HANG: begin
				state_nxt = ST_HANG;
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
		if (stuck) state_nxt = ST_HANG;    // Overrides everything
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	assign run = (state == ST_RUN);
	assign frame_done = (state == ST_DONE);
	assign hang = (state == ST_HANG);

	// ***********************************************************************
	// Checks

	a_done_empty: assert property (@(posedge clk) disable iff (!rst_n)
		frame_done |-> !any_valid);

endmodule

/* hdl/rt_top.sv */
`timescale 1ns/10ps

module rt_top import rt_scene_pkg::*, rt_link_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	output pixel_t pix,
	output logic pix_valid,
	input  logic pix_stall,
	output logic frame_done,
	output logic hang
);

	ray_t ray;
	logic ray_valid;
	logic ray_stall;
	hit_t hit;
	logic hit_valid;
	logic hit_stall;
	logic gen_done;
	logic busy;
	logic run;
	logic any_valid;
	logic stuck;
	link_vec_t links;

	// ***********************************************************************
	// Link status for the monitor

	assign links[0] = '{valid: ray_valid, stall: ray_stall};
	assign links[1] = '{valid: hit_valid, stall: hit_stall};
	assign links[2] = '{valid: pix_valid, stall: pix_stall};

	ray_gen gen0 (.clk, .rst_n, .run, .start, .ray, .ray_valid, .ray_stall, .gen_done);

	box_trav trav0 (.clk, .rst_n, .ray, .ray_valid, .ray_stall, .hit, .hit_valid, .hit_stall,
		.busy);

	pixel_shader shade0 (.clk, .rst_n, .hit, .hit_valid, .hit_stall, .pix, .pix_valid,
		.pix_stall);

	link_monitor mon0 (
		.clk,
		.rst_n,
		.links,
		.any_valid,
		.any_move(),     // Only used inside the monitor
		.stuck
	);

	rt_ctrl ctrl0 (.clk, .rst_n, .start, .gen_done, .busy, .any_valid, .stuck, .run,
		.frame_done, .hang);

endmodule

/* tb/rt_tb.sv */
`timescale 1ns/10ps
`include "rt_settings.svh"

module rt_tb import rt_scene_pkg::*; ();

	localparam int PIXELS = `RT_WIDTH * `RT_HEIGHT;
	localparam int FRAME_TIMEOUT = 4000;     // Cycles

	typedef enum logic [1:0] {
		STALL_NONE,
		STALL_RANDOM,
		STALL_HOLD
	} stall_mode_t;

	logic clk;
	logic rst_n;
	logic start;
	logic pix_stall;
	pixel_t pix;
	logic pix_valid;
	logic frame_done;
	logic hang;

	stall_mode_t stall_mode;
	integer seed;
	integer rnd;
	logic pix_xfer;
	int unsigned exp_idx;
	int unsigned frame_pixels;
	coord_t exp_x;
	coord_t exp_y;
	color_t exp_color;
	logic exp_last;
	logic last_seen;
	logic hang_seen;

	rt_top dut0 (.clk, .rst_n, .start, .pix, .pix_valid, .pix_stall, .frame_done, .hang);

	// ***********************************************************************
	// Reference model

	function automatic color_t expected_color(input coord_t x, input coord_t y);
		color_t color;
		depth_t nearest;
		logic found;
		color = BG_COLOR;
		nearest = '1;
		found = 1'b0;
		for (int i = 0; i < `RT_NUM_BOXES; i++) begin
			if (x >= BOX_TABLE[i].x_min && x <= BOX_TABLE[i].x_max &&
				y >= BOX_TABLE[i].y_min && y <= BOX_TABLE[i].y_max &&
				(!found || BOX_TABLE[i].z < nearest)) begin
				found = 1'b1;
				nearest = BOX_TABLE[i].z;
				color = BOX_TABLE[i].color;
			end
		end
		return color;
	endfunction

	assign pix_xfer = pix_valid && !pix_stall;
	assign exp_x = coord_t'(exp_idx % `RT_WIDTH);
	assign exp_y = coord_t'(exp_idx / `RT_WIDTH);
	assign exp_last = (exp_idx == PIXELS - 1);

	always_comb begin
		exp_color = expected_color(exp_x, exp_y);
	end

	// Scoreboard position and frame bookkeeping
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exp_idx <= 0;
			frame_pixels <= 0;
			last_seen <= 1'b0;
			hang_seen <= 1'b0;
		end else begin
			if (pix_xfer) begin
				exp_idx <= exp_last ? 0 : exp_idx + 1;    // Wraps for the next frame
				frame_pixels <= frame_pixels + 1;
				if (pix.last) last_seen <= 1'b1;
			end
			if (frame_done) begin
				frame_pixels <= 0;
				last_seen <= 1'b0;
			end
			if (hang) hang_seen <= 1'b1;
		end
	end

	// ***********************************************************************
	// Failure reporting

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		fail_run($sformatf("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual));
	endtask

	// ***********************************************************************
	// Checks

	a_pix_x: assert property (@(posedge clk) disable iff (!rst_n) pix_xfer |-> pix.x == exp_x)
		else report_mismatch("pix.x", $sampled(exp_x), $sampled(pix.x));
	a_pix_y: assert property (@(posedge clk) disable iff (!rst_n) pix_xfer |-> pix.y == exp_y)
		else report_mismatch("pix.y", $sampled(exp_y), $sampled(pix.y));
	a_pix_color: assert property (@(posedge clk) disable iff (!rst_n)
		pix_xfer |-> pix.color == exp_color)
		else report_mismatch("pix.color", $sampled(exp_color), $sampled(pix.color));
	a_pix_last: assert property (@(posedge clk) disable iff (!rst_n)
		pix_xfer |-> pix.last == exp_last)
		else report_mismatch("pix.last", $sampled(exp_last), $sampled(pix.last));
	a_pix_hold: assert property (@(posedge clk) disable iff (!rst_n)
		pix_valid && pix_stall |=> pix_valid && $stable(pix))
		else fail_run("Pixel changed or disappeared while stalled");
	a_done_after_last: assert property (@(posedge clk) disable iff (!rst_n)
		frame_done |-> last_seen && !pix_valid)
		else fail_run("frame_done came before the last pixel left the pipeline");
	a_done_count: assert property (@(posedge clk) disable iff (!rst_n)
		frame_done |-> frame_pixels == PIXELS)
		else report_mismatch("frame pixel count", PIXELS, $sampled(frame_pixels));
	a_hang_sticky: assert property (@(posedge clk) disable iff (!rst_n) hang |=> hang)
		else fail_run("hang dropped before reset");
	a_no_done_after_hang: assert property (@(posedge clk) disable iff (!rst_n)
		hang_seen |-> !frame_done)
		else fail_run("frame_done pulsed after a hang");

	// ***********************************************************************
	// Clock and stimulus

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		#2;
		case (stall_mode)
			STALL_RANDOM: begin
				rnd = $random(seed);
				pix_stall = rnd[0];
			end
			STALL_HOLD: pix_stall = 1'b1;
			default: pix_stall = 1'b0;
		endcase
	end

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (5) tick();
		rst_n = 1'b1;
		assert (!frame_done && !hang && !pix_valid)
			else fail_run("Outputs not low after reset");
	endtask

	task automatic pulse_start();
		start = 1'b1;
		tick();
		start = 1'b0;
	endtask

	task automatic wait_frame_done(input int limit);
		int n;
		n = 0;
		while (!frame_done && n < limit) begin
			tick();
			n++;
		end
		if (!frame_done) fail_run("Timed out waiting for frame_done");
	endtask

	task automatic wait_pixels(input int unsigned count, input int limit);
		int n;
		n = 0;
		while (frame_pixels < count && n < limit) begin
			tick();
			n++;
		end
		if (frame_pixels < count) fail_run("Timed out waiting for pixels");
	endtask

	task automatic wait_hang(input int limit);
		int n;
		n = 0;
		while (!hang && n < limit) begin
			tick();
			n++;
		end
		if (!hang) fail_run("hang did not rise under a held stall");
	endtask

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		pix_stall = 1'b0;
		stall_mode = STALL_NONE;
		seed = 32'h787064c3;
		apply_reset();

		// Clean frame, then a stalled frame with a stray start, then a repeat
		pulse_start();
		wait_frame_done(FRAME_TIMEOUT);
		tick();
		stall_mode <= STALL_RANDOM;
		pulse_start();
		wait_pixels(10, FRAME_TIMEOUT);
		pulse_start();    // Lands in ST_RUN
		wait_frame_done(FRAME_TIMEOUT);
		tick();
		stall_mode <= STALL_NONE;
		pulse_start();
		wait_frame_done(FRAME_TIMEOUT);
		tick();

		// Hang detection
		pulse_start();
		wait_pixels(5, FRAME_TIMEOUT);
		stall_mode <= STALL_HOLD;
		wait_hang(`RT_HANG_LIMIT + 40);
		repeat (10) tick();
		stall_mode <= STALL_NONE;
		repeat (200) tick();
		pulse_start();
		repeat (50) tick();
		assert (hang) else fail_run("hang cleared without a reset");

		// Recovery after reset
		apply_reset();
		stall_mode <= STALL_RANDOM;
		pulse_start();
		wait_frame_done(FRAME_TIMEOUT);
		repeat (5) tick();

		$display("Done: no errors");
		$finish;
	end

endmodule

/* files.f */
+incdir+hdl
hdl/rt_link_pkg.sv
hdl/rt_scene_pkg.sv
hdl/ray_gen.sv
hdl/box_trav.sv
hdl/pixel_shader.sv
hdl/link_monitor.sv
hdl/rt_ctrl.sv
hdl/rt_top.sv
tb/rt_tb.sv
